// ==== sources.f ====
design/rvv_cfg_pkg.sv
design/rvv_uop_pkg.sv
design/rvv_cmd_queue.sv
design/rvv_decode_unit.sv
design/rvv_decode_ctrl.sv
design/rvv_uop_queue.sv
design/rvv_decode_top.sv
verification/rvv_decode_tb.sv

// ==== Makefile ====
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= rvv_decode_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/rvv_decode_tb.sv ====
// rvv decode testbench: directed command streams checked against a reference uop list
module rvv_decode_tb
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  localparam int drive_delay  = 2;
  localparam int num_tests    = 6;
  localparam int total_cmds   = 72;
  // at most eight uops per command, four cycles each with consumer stalls
  localparam int cycle_limit  = reset_cycles + total_cmds * 8 * 4 + num_tests * 100;
  localparam int uop_bits     = opcode_width + 3 * vreg_width + uop_index_width + 1;

  logic                        clk;
  logic                        arst_n;
  logic                        cmd_push;
  opcode_e                     cmd_opcode;
  logic [vreg_width-1:0]       cmd_vd;
  logic [vreg_width-1:0]       cmd_vs1;
  logic [vreg_width-1:0]       cmd_vs2;
  lmul_e                       cmd_lmul;
  logic [cmd_credit_width-1:0] cmd_credit_ret;
  logic                        uop_valid;
  opcode_e                     uop_opcode;
  logic [vreg_width-1:0]       uop_vd;
  logic [vreg_width-1:0]       uop_vs1;
  logic [vreg_width-1:0]       uop_vs2;
  logic [uop_index_width-1:0]  uop_index;
  logic                        uop_last;
  logic                        uop_pop;

  logic [15:0]         lfsr_state;
  logic [uop_bits-1:0] exp_q [$];
  int                  credits;
  int                  credits_returned;
  int                  cmds_sent;
  int                  errors;
  int                  tests_run;
  int                  tests_bad;
  int                  cycle_cnt;
  logic                collect_en;
  logic                stall_en;
  logic                take_uop;

  rvv_decode_top DUT (
    .clk, .arst_n,
    .cmd_push, .cmd_opcode, .cmd_vd, .cmd_vs1, .cmd_vs2, .cmd_lmul,
    .cmd_credit_ret,
    .uop_valid, .uop_opcode, .uop_vd, .uop_vs1, .uop_vs2, .uop_index, .uop_last,
    .uop_pop
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // galois form, taps for a 16 bit maximal sequence
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_step());
    end
    return v;
  endfunction

  // one uop per group member, registers offset by the member index
  task automatic add_expected(input opcode_e op, input logic [vreg_width-1:0] vd,
                              input logic [vreg_width-1:0] vs1,
                              input logic [vreg_width-1:0] vs2, input lmul_e lm);
    int n;
    n = 1 << int'(lm);
    for (int i = 0; i < n; i++) begin
      exp_q.push_back({op, vd + vreg_width'(i), vs1 + vreg_width'(i),
                       vs2 + vreg_width'(i), uop_index_width'(i), i == n - 1});
    end
  endtask

  task automatic send_cmd(input opcode_e op, input logic [vreg_width-1:0] vd,
                          input logic [vreg_width-1:0] vs1,
                          input logic [vreg_width-1:0] vs2, input lmul_e lm);
    while (credits == 0) begin
      cmd_push = 1'b0;
      @(posedge clk);
      #(drive_delay);
    end
    cmd_push   = 1'b1;
    cmd_opcode = op;
    cmd_vd     = vd;
    cmd_vs1    = vs1;
    cmd_vs2    = vs2;
    cmd_lmul   = lm;
    credits    = credits - 1;
    cmds_sent  = cmds_sent + 1;
    add_expected(op, vd, vs1, vs2, lm);
    @(posedge clk);
    #(drive_delay);
    cmd_push = 1'b0;
  endtask

  task automatic check_uop();
    logic [uop_bits-1:0] got;
    logic [uop_bits-1:0] exp;
    got = {uop_opcode, uop_vd, uop_vs1, uop_vs2, uop_index, uop_last};
    assert (exp_q.size() != 0) else begin
      $display("uop popped at %0t while no uop was expected", $time);
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      assert (got == exp) else begin
        $display("CHECK FAILED @%0t: uop {op,vd,vs1,vs2,idx,last} expected %h got %h",
                 $time, exp, got);
        errors++;
      end
    end
  endtask

  // sample at +1, drive uop_pop at the drive slot
  always @(posedge clk) begin
    #1;
    if (arst_n) begin
      credits          = credits + int'(cmd_credit_ret);
      credits_returned = credits_returned + int'(cmd_credit_ret);
      take_uop         = collect_en && uop_valid;
      if (take_uop && stall_en && rand_bits(1) == 0) begin
        take_uop = 1'b0;
      end
      if (take_uop) begin
        check_uop();
      end
    end else begin
      take_uop = 1'b0;
    end
    #(drive_delay - 1);
    uop_pop = take_uop;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d uops never arrived", cycle_cnt, exp_q.size());
      $display("test failed");
      $finish;
    end
  end

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #(drive_delay);
    end
    // credit return trails the last command pop
    repeat (3) @(posedge clk);
    #(drive_delay);
    assert (!uop_valid) else begin
      $display("CHECK FAILED @%0t: uop_valid still high after all uops arrived", $time);
      errors++;
    end
    assert (credits == cmd_depth) else begin
      $display("CHECK FAILED @%0t: credit counter at %0d after drain", $time, credits);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("%s: clean", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_single_lmul1();
    int err0;
    err0       = errors;
    collect_en = 1'b1;
    stall_en   = 1'b0;
    send_cmd(OP_VADD, 5'd3, 5'd10, 5'd20, LMUL_1);
    wait_drain();
    finish_test("single lmul1", err0);
  endtask

  task automatic test_lmul8();
    int err0;
    err0 = errors;
    send_cmd(OP_VMUL, 5'd8, 5'd16, 5'd24, LMUL_8);
    wait_drain();
    finish_test("lmul8 group", err0);
  endtask

  task automatic test_program_order();
    int err0;
    err0       = errors;
    collect_en = 1'b0;
    send_cmd(OP_VADD, 5'd0, 5'd1, 5'd2, LMUL_1);
    send_cmd(OP_VSUB, 5'd4, 5'd5, 5'd6, LMUL_2);
    send_cmd(OP_VMUL, 5'd7, 5'd9, 5'd11, LMUL_1);
    send_cmd(OP_VAND, 5'd12, 5'd13, 5'd14, LMUL_1);
    send_cmd(OP_VADD, 5'd16, 5'd18, 5'd20, LMUL_2);
    send_cmd(OP_VSUB, 5'd21, 5'd22, 5'd23, LMUL_1);
    send_cmd(OP_VMUL, 5'd24, 5'd26, 5'd28, LMUL_2);
    send_cmd(OP_VAND, 5'd30, 5'd31, 5'd29, LMUL_2);
    // uop queue is nearly full here, so the tail waits and shares windows
    send_cmd(OP_VADD, 5'd1, 5'd3, 5'd5, LMUL_1);
    send_cmd(OP_VSUB, 5'd8, 5'd10, 5'd12, LMUL_2);
    send_cmd(OP_VMUL, 5'd15, 5'd17, 5'd19, LMUL_1);
    send_cmd(OP_VAND, 5'd25, 5'd27, 5'd2, LMUL_2);
    collect_en = 1'b1;
    wait_drain();
    finish_test("program order", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    int n;
    err0       = errors;
    collect_en = 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_cmd(OP_VAND, vreg_width'(4 * i), vreg_width'(i + 1), vreg_width'(31 - i), LMUL_4);
    end
    n = 0;
    while (int'(DUT.u_uop_queue.count) < 13 && n < 50) begin
      @(posedge clk);
      #(drive_delay);
      n++;
    end
    assert (n < 50) else begin
      $display("uop queue never filled to 13 entries with the consumer stopped");
      errors++;
    end
    repeat (8) @(posedge clk);
    #(drive_delay);
    assert (uop_valid) else begin
      $display("CHECK FAILED @%0t: uop_valid low while the consumer was stopped", $time);
      errors++;
    end
    collect_en = 1'b1;
    wait_drain();
    finish_test("back-pressure", err0);
  endtask

  task automatic test_credits();
    int err0;
    int sent0;
    err0             = errors;
    sent0            = cmds_sent;
    credits_returned = 0;
    stall_en         = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_cmd(opcode_e'(2'(i)), vreg_width'(i), vreg_width'(i + 8), vreg_width'(i + 16),
               LMUL_8);
    end
    wait_drain();
    assert (credits_returned == cmds_sent - sent0) else begin
      $display("CHECK FAILED @%0t: %0d credits returned for %0d commands",
               $time, credits_returned, cmds_sent - sent0);
      errors++;
    end
    finish_test("credit return", err0);
  endtask

  task automatic test_random_mix();
    int      err0;
    opcode_e op;
    lmul_e   lm;
    logic [vreg_width-1:0] vd;
    logic [vreg_width-1:0] vs1;
    logic [vreg_width-1:0] vs2;
    err0     = errors;
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      op  = opcode_e'(2'(rand_bits(2)));
      vd  = vreg_width'(rand_bits(vreg_width));
      vs1 = vreg_width'(rand_bits(vreg_width));
      vs2 = vreg_width'(rand_bits(vreg_width));
      lm  = lmul_e'(2'(rand_bits(2)));
      send_cmd(op, vd, vs1, vs2, lm);
    end
    wait_drain();
    finish_test("random mix", err0);
  endtask

  initial begin
    lfsr_state       = 16'd27258;
    arst_n           = 1'b0;
    cmd_push         = 1'b0;
    cmd_opcode       = OP_VADD;
    cmd_vd           = '0;
    cmd_vs1          = '0;
    cmd_vs2          = '0;
    cmd_lmul         = LMUL_1;
    uop_pop          = 1'b0;
    credits          = cmd_depth;
    credits_returned = 0;
    cmds_sent        = 0;
    errors           = 0;
    tests_run        = 0;
    tests_bad        = 0;
    cycle_cnt        = 0;
    collect_en       = 1'b0;
    stall_en         = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    arst_n = 1'b1;
    test_single_lmul1();
    test_lmul8();
    test_program_order();
    test_backpressure();
    test_credits();
    test_random_mix();
    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== design/rvv_decode_top.sv ====
// rvv decode back end: command queue, two decode units, controller and uop queue
module rvv_decode_top
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        cmd_push,
  input  opcode_e                     cmd_opcode,
  input  logic [vreg_width-1:0]       cmd_vd,
  input  logic [vreg_width-1:0]       cmd_vs1,
  input  logic [vreg_width-1:0]       cmd_vs2,
  input  lmul_e                       cmd_lmul,
  output logic [cmd_credit_width-1:0] cmd_credit_ret,
  output logic                        uop_valid,
  output opcode_e                     uop_opcode,
  output logic [vreg_width-1:0]       uop_vd,
  output logic [vreg_width-1:0]       uop_vs1,
  output logic [vreg_width-1:0]       uop_vs2,
  output logic [uop_index_width-1:0]  uop_index,
  output logic                        uop_last,
  input  logic                        uop_pop
);

  logic                       pkg0_valid;
  logic                       pkg1_valid;
  opcode_e                    pkg0_opcode;
  opcode_e                    pkg1_opcode;
  logic [vreg_width-1:0]      pkg0_vd;
  logic [vreg_width-1:0]      pkg0_vs1;
  logic [vreg_width-1:0]      pkg0_vs2;
  logic [vreg_width-1:0]      pkg1_vd;
  logic [vreg_width-1:0]      pkg1_vs1;
  logic [vreg_width-1:0]      pkg1_vs2;
  lmul_e                      pkg0_lmul;
  lmul_e                      pkg1_lmul;
  logic                       pop0;
  logic                       pop1;
  logic [uop_index_width-1:0] uop_index_remain;

  // decode windows
  logic [num_de_uop-1:0]      u0_valid;
  logic [num_de_uop-1:0]      u1_valid;
  logic [num_de_uop-1:0]      u0_last;
  logic [num_de_uop-1:0]      u1_last;
  opcode_e                    u0_opcode [num_de_uop];
  opcode_e                    u1_opcode [num_de_uop];
  logic [vreg_width-1:0]      u0_vd     [num_de_uop];
  logic [vreg_width-1:0]      u0_vs1    [num_de_uop];
  logic [vreg_width-1:0]      u0_vs2    [num_de_uop];
  logic [vreg_width-1:0]      u1_vd     [num_de_uop];
  logic [vreg_width-1:0]      u1_vs1    [num_de_uop];
  logic [vreg_width-1:0]      u1_vs2    [num_de_uop];
  logic [uop_index_width-1:0] u0_idx    [num_de_uop];
  logic [uop_index_width-1:0] u1_idx    [num_de_uop];

  // uop queue write side
  logic                       push0;
  logic                       push1;
  logic                       push2;
  logic                       push3;
  opcode_e                    push_opcode [num_de_uop];
  logic [vreg_width-1:0]      push_vd     [num_de_uop];
  logic [vreg_width-1:0]      push_vs1    [num_de_uop];
  logic [vreg_width-1:0]      push_vs2    [num_de_uop];
  logic [uop_index_width-1:0] push_idx    [num_de_uop];
  logic [num_de_uop-1:0]      push_last;
  logic                       fifo_full;
  logic                       fifo_1left_to_full;
  logic                       fifo_2left_to_full;
  logic                       fifo_3left_to_full;

  rvv_cmd_queue u_cmd_queue (
    .clk, .arst_n,
    .cmd_push, .cmd_opcode, .cmd_vd, .cmd_vs1, .cmd_vs2, .cmd_lmul,
    .pop0, .pop1,
    .pkg0_valid, .pkg0_opcode, .pkg0_vd, .pkg0_vs1, .pkg0_vs2, .pkg0_lmul,
    .pkg1_valid, .pkg1_opcode, .pkg1_vd, .pkg1_vs1, .pkg1_vs2, .pkg1_lmul,
    .cmd_credit_ret
  );

  // head command, resumed at the remaining index
  rvv_decode_unit #(.follower(0)) u_decode_unit0 (
    .pkg_valid(pkg0_valid), .pkg_opcode(pkg0_opcode), .pkg_vd(pkg0_vd),
    .pkg_vs1(pkg0_vs1), .pkg_vs2(pkg0_vs2), .pkg_lmul(pkg0_lmul),
    .uop_index(uop_index_remain),
    .uop_valid(u0_valid), .uop_opcode(u0_opcode), .uop_vd(u0_vd),
    .uop_vs1(u0_vs1), .uop_vs2(u0_vs2), .uop_idx(u0_idx), .uop_last(u0_last)
  );

  // next command, always from its first uop
  rvv_decode_unit #(.follower(1)) u_decode_unit1 (
    .pkg_valid(pkg1_valid), .pkg_opcode(pkg1_opcode), .pkg_vd(pkg1_vd),
    .pkg_vs1(pkg1_vs1), .pkg_vs2(pkg1_vs2), .pkg_lmul(pkg1_lmul),
    .uop_index(),
    .uop_valid(u1_valid), .uop_opcode(u1_opcode), .uop_vd(u1_vd),
    .uop_vs1(u1_vs1), .uop_vs2(u1_vs2), .uop_idx(u1_idx), .uop_last(u1_last)
  );

  rvv_decode_ctrl u_decode_ctrl (
    .clk, .arst_n,
    .pkg0_valid, .unit0_uop_valid(u0_valid), .unit0_opcode(u0_opcode),
    .unit0_vd(u0_vd), .unit0_vs1(u0_vs1), .unit0_vs2(u0_vs2),
    .unit0_idx(u0_idx), .unit0_last(u0_last),
    .pkg1_valid, .unit1_uop_valid(u1_valid), .unit1_opcode(u1_opcode),
    .unit1_vd(u1_vd), .unit1_vs1(u1_vs1), .unit1_vs2(u1_vs2),
    .unit1_idx(u1_idx), .unit1_last(u1_last),
    .uop_index_remain, .pop0, .pop1,
    .push0, .push1, .push2, .push3,
    .push_opcode, .push_vd, .push_vs1, .push_vs2, .push_idx, .push_last,
    .fifo_full, .fifo_1left_to_full, .fifo_2left_to_full, .fifo_3left_to_full
  );

  rvv_uop_queue u_uop_queue (
    .clk, .arst_n,
    .push0, .push1, .push2, .push3,
    .push_opcode, .push_vd, .push_vs1, .push_vs2, .push_idx, .push_last,
    .fifo_full, .fifo_1left_to_full, .fifo_2left_to_full, .fifo_3left_to_full,
    .uop_valid, .uop_opcode, .uop_vd, .uop_vs1, .uop_vs2, .uop_index, .uop_last,
    .uop_pop
  );

endmodule

// ==== design/rvv_uop_queue.sv ====
// rvv uop queue: four-push one-pop uop FIFO with nearly-full flags
module rvv_uop_queue
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       push0,
  input  logic                       push1,
  input  logic                       push2,
  input  logic                       push3,
  input  opcode_e                    push_opcode [num_de_uop],
  input  logic [vreg_width-1:0]      push_vd     [num_de_uop],
  input  logic [vreg_width-1:0]      push_vs1    [num_de_uop],
  input  logic [vreg_width-1:0]      push_vs2    [num_de_uop],
  input  logic [uop_index_width-1:0] push_idx    [num_de_uop],
  input  logic [num_de_uop-1:0]      push_last,
  output logic                       fifo_full,
  output logic                       fifo_1left_to_full,
  output logic                       fifo_2left_to_full,
  output logic                       fifo_3left_to_full,
  output logic                       uop_valid,
  output opcode_e                    uop_opcode,
  output logic [vreg_width-1:0]      uop_vd,
  output logic [vreg_width-1:0]      uop_vs1,
  output logic [vreg_width-1:0]      uop_vs2,
  output logic [uop_index_width-1:0] uop_index,
  output logic                       uop_last,
  input  logic                       uop_pop
);

  opcode_e                     opcode_mem [uq_depth];
  logic [vreg_width-1:0]       vd_mem     [uq_depth];
  logic [vreg_width-1:0]       vs1_mem    [uq_depth];
  logic [vreg_width-1:0]       vs2_mem    [uq_depth];
  logic [uop_index_width-1:0]  idx_mem    [uq_depth];
  logic                        last_mem   [uq_depth];
  logic [uq_ptr_width-1:0]     wr_ptr;
  logic [uq_ptr_width-1:0]     rd_ptr;
  logic [uq_ptr_width:0]       count;
  logic [num_de_uop-1:0]       push_vec;
  logic [uq_ptr_width-1:0]     slot_addr [num_de_uop];
  logic [num_de_uop_width-1:0] wr_cnt;
  logic                        pop;

  assign push_vec = {push3, push2, push1, push0};
  assign pop      = uop_pop && uop_valid;

  // each active slot goes right after the ones before it
  always_comb begin
    wr_cnt = '0;
    for (int s = 0; s < num_de_uop; s++) begin
      slot_addr[s] = wr_ptr + uq_ptr_width'(wr_cnt);
      wr_cnt       = wr_cnt + num_de_uop_width'(push_vec[s]);
    end
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < num_de_uop; s++) begin
      if (push_vec[s]) begin
        opcode_mem[slot_addr[s]] <= push_opcode[s];
        vd_mem[slot_addr[s]]     <= push_vd[s];
        vs1_mem[slot_addr[s]]    <= push_vs1[s];
        vs2_mem[slot_addr[s]]    <= push_vs2[s];
        idx_mem[slot_addr[s]]    <= push_idx[s];
        last_mem[slot_addr[s]]   <= push_last[s];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + uq_ptr_width'(wr_cnt);
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (uq_ptr_width+1)'(wr_cnt) - (uq_ptr_width+1)'(pop);
    end
  end

  // exact occupancy levels, the controller needs all four clear
  assign fifo_full          = (count == (uq_ptr_width+1)'(uq_depth));
  assign fifo_1left_to_full = (count == (uq_ptr_width+1)'(uq_depth - 1));
  assign fifo_2left_to_full = (count == (uq_ptr_width+1)'(uq_depth - 2));
  assign fifo_3left_to_full = (count == (uq_ptr_width+1)'(uq_depth - 3));

  assign uop_valid  = (count != '0);
  assign uop_opcode = opcode_mem[rd_ptr];
  assign uop_vd     = vd_mem[rd_ptr];
  assign uop_vs1    = vs1_mem[rd_ptr];
  assign uop_vs2    = vs2_mem[rd_ptr];
  assign uop_index  = idx_mem[rd_ptr];
  assign uop_last   = last_mem[rd_ptr];

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    count + (uq_ptr_width+1)'(wr_cnt) <= (uq_ptr_width+1)'(uq_depth));

endmodule

// ==== design/rvv_decode_ctrl.sv ====
// rvv decode controller: packs two decode windows into the uop queue in order
module rvv_decode_ctrl
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       pkg0_valid,
  input  logic [num_de_uop-1:0]      unit0_uop_valid,
  input  opcode_e                    unit0_opcode [num_de_uop],
  input  logic [vreg_width-1:0]      unit0_vd     [num_de_uop],
  input  logic [vreg_width-1:0]      unit0_vs1    [num_de_uop],
  input  logic [vreg_width-1:0]      unit0_vs2    [num_de_uop],
  input  logic [uop_index_width-1:0] unit0_idx    [num_de_uop],
  input  logic [num_de_uop-1:0]      unit0_last,
  input  logic                       pkg1_valid,
  input  logic [num_de_uop-1:0]      unit1_uop_valid,
  input  opcode_e                    unit1_opcode [num_de_uop],
  input  logic [vreg_width-1:0]      unit1_vd     [num_de_uop],
  input  logic [vreg_width-1:0]      unit1_vs1    [num_de_uop],
  input  logic [vreg_width-1:0]      unit1_vs2    [num_de_uop],
  input  logic [uop_index_width-1:0] unit1_idx    [num_de_uop],
  input  logic [num_de_uop-1:0]      unit1_last,
  output logic [uop_index_width-1:0] uop_index_remain,
  output logic                       pop0,
  output logic                       pop1,
  output logic                       push0,
  output logic                       push1,
  output logic                       push2,
  output logic                       push3,
  output opcode_e                    push_opcode [num_de_uop],
  output logic [vreg_width-1:0]      push_vd     [num_de_uop],
  output logic [vreg_width-1:0]      push_vs1    [num_de_uop],
  output logic [vreg_width-1:0]      push_vs2    [num_de_uop],
  output logic [uop_index_width-1:0] push_idx    [num_de_uop],
  output logic [num_de_uop-1:0]      push_last,
  input  logic                       fifo_full,
  input  logic                       fifo_1left_to_full,
  input  logic                       fifo_2left_to_full,
  input  logic                       fifo_3left_to_full
);

  logic [num_de_uop_width-1:0] quantity;
  logic [num_de_uop-1:0]       free_mask;
  logic [num_de_uop-1:0]       push_valid;
  logic [de_sel_width-1:0]     u1_sel;
  logic                        unit0_done;
  logic                        unit1_done;
  logic                        fifo_ready;
  logic                        idx_clear;
  logic                        idx_en_unit0;
  logic                        idx_en_unit1;

  // unit0 valids are contiguous, a plain count is enough
  always_comb begin
    quantity = '0;
    for (int s = 0; s < num_de_uop; s++) begin
      quantity = quantity + num_de_uop_width'(unit0_uop_valid[s]);
    end
  end

  // a partial window always ends the command
  assign unit0_done = (quantity != num_de_uop_width'(num_de_uop)) ||
                      unit0_last[num_de_uop-1];
  // slots left over for unit1
  assign free_mask  = {num_de_uop{1'b1}} >> quantity;
  assign unit1_done = (unit1_uop_valid == '0) || (|(unit1_last & free_mask));

  assign fifo_ready = !(fifo_full || fifo_1left_to_full ||
                        fifo_2left_to_full || fifo_3left_to_full);

  assign pop0 = pkg0_valid && unit0_done && fifo_ready;
  assign pop1 = pkg1_valid && unit1_done && pop0;

  // remaining index for the head command
  assign idx_clear    = (pop0 && !pkg1_valid) || pop1;
  assign idx_en_unit1 = pop0 && pkg1_valid && !unit1_done;
  assign idx_en_unit0 = fifo_ready && pkg0_valid && !unit0_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_index_remain <= '0;
    end else if (idx_clear) begin
      uop_index_remain <= '0;
    end else if (idx_en_unit1) begin
      // second command becomes head, partly written
      uop_index_remain <= uop_index_width'(num_de_uop) - uop_index_width'(quantity);
    end else if (idx_en_unit0) begin
      uop_index_remain <= uop_index_remain + uop_index_width'(num_de_uop);
    end
  end

  // head uops first, then unit1 shifted up by quantity
  always_comb begin
    u1_sel = '0;
    for (int s = 0; s < num_de_uop; s++) begin
      if (num_de_uop_width'(s) < quantity) begin
        push_valid[s]  = unit0_uop_valid[s];
        push_opcode[s] = unit0_opcode[s];
        push_vd[s]     = unit0_vd[s];
        push_vs1[s]    = unit0_vs1[s];
        push_vs2[s]    = unit0_vs2[s];
        push_idx[s]    = unit0_idx[s];
        push_last[s]   = unit0_last[s];
      end else begin
        u1_sel         = de_sel_width'(num_de_uop_width'(s) - quantity);
        push_valid[s]  = unit1_uop_valid[u1_sel];
        push_opcode[s] = unit1_opcode[u1_sel];
        push_vd[s]     = unit1_vd[u1_sel];
        push_vs1[s]    = unit1_vs1[u1_sel];
        push_vs2[s]    = unit1_vs2[u1_sel];
        push_idx[s]    = unit1_idx[u1_sel];
        push_last[s]   = unit1_last[u1_sel];
      end
    end
  end

  assign push0 = push_valid[0] && fifo_ready;
  assign push1 = push_valid[1] && fifo_ready;
  assign push2 = push_valid[2] && fifo_ready;
  assign push3 = push_valid[3] && fifo_ready;

  // uop queue writes slots back to back, so gaps would reorder uops
  a_push_contiguous: assert property (@(posedge clk) disable iff (!arst_n)
    {push3, push2, push1, push0} inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111});

endmodule

// ==== design/rvv_decode_unit.sv ====
// rvv decode unit: expands one command into a window of up to four uops
module rvv_decode_unit
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
#(
  parameter int follower = 0
)
(
  input  logic                       pkg_valid,
  input  opcode_e                    pkg_opcode,
  input  logic [vreg_width-1:0]      pkg_vd,
  input  logic [vreg_width-1:0]      pkg_vs1,
  input  logic [vreg_width-1:0]      pkg_vs2,
  input  lmul_e                      pkg_lmul,
  input  logic [uop_index_width-1:0] uop_index,
  output logic [num_de_uop-1:0]      uop_valid,
  output opcode_e                    uop_opcode [num_de_uop],
  output logic [vreg_width-1:0]      uop_vd     [num_de_uop],
  output logic [vreg_width-1:0]      uop_vs1    [num_de_uop],
  output logic [vreg_width-1:0]      uop_vs2    [num_de_uop],
  output logic [uop_index_width-1:0] uop_idx    [num_de_uop],
  output logic [num_de_uop-1:0]      uop_last
);

  // one extra bit so a count of eight fits
  logic [uop_index_width:0] uop_cnt;
  logic [uop_index_width:0] win_base;
  logic [uop_index_width:0] slot_idx [num_de_uop];

  always_comb begin
    case (pkg_lmul)
      LMUL_1:  uop_cnt = (uop_index_width+1)'(1);
      LMUL_2:  uop_cnt = (uop_index_width+1)'(2);
      LMUL_4:  uop_cnt = (uop_index_width+1)'(4);
      default: uop_cnt = (uop_index_width+1)'(8);
    endcase
  end

  // a follower always sees a fresh command
  assign win_base = (follower != 0) ? '0 : {1'b0, uop_index};

  always_comb begin
    for (int s = 0; s < num_de_uop; s++) begin
      slot_idx[s]   = win_base + (uop_index_width+1)'(s);
      uop_valid[s]  = pkg_valid && (slot_idx[s] < uop_cnt);
      uop_last[s]   = pkg_valid && (slot_idx[s] == uop_cnt - 1'b1);
      uop_opcode[s] = pkg_opcode;
      // group member i uses base register plus i
      uop_vd[s]     = pkg_vd + vreg_width'(slot_idx[s]);
      uop_vs1[s]    = pkg_vs1 + vreg_width'(slot_idx[s]);
      uop_vs2[s]    = pkg_vs2 + vreg_width'(slot_idx[s]);
      uop_idx[s]    = slot_idx[s][uop_index_width-1:0];
    end
  end

endmodule

// ==== design/rvv_cmd_queue.sv ====
// rvv command queue: FIFO exposing the two oldest commands, with credit return
module rvv_cmd_queue
  import rvv_cfg_pkg::*, rvv_uop_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        cmd_push,
  input  opcode_e                     cmd_opcode,
  input  logic [vreg_width-1:0]       cmd_vd,
  input  logic [vreg_width-1:0]       cmd_vs1,
  input  logic [vreg_width-1:0]       cmd_vs2,
  input  lmul_e                       cmd_lmul,
  input  logic                        pop0,
  input  logic                        pop1,
  output logic                        pkg0_valid,
  output opcode_e                     pkg0_opcode,
  output logic [vreg_width-1:0]       pkg0_vd,
  output logic [vreg_width-1:0]       pkg0_vs1,
  output logic [vreg_width-1:0]       pkg0_vs2,
  output lmul_e                       pkg0_lmul,
  output logic                        pkg1_valid,
  output opcode_e                     pkg1_opcode,
  output logic [vreg_width-1:0]       pkg1_vd,
  output logic [vreg_width-1:0]       pkg1_vs1,
  output logic [vreg_width-1:0]       pkg1_vs2,
  output lmul_e                       pkg1_lmul,
  output logic [cmd_credit_width-1:0] cmd_credit_ret
);

  opcode_e                     opcode_mem [cmd_depth];
  logic [vreg_width-1:0]       vd_mem     [cmd_depth];
  logic [vreg_width-1:0]       vs1_mem    [cmd_depth];
  logic [vreg_width-1:0]       vs2_mem    [cmd_depth];
  lmul_e                       lmul_mem   [cmd_depth];
  logic [cmd_ptr_width-1:0]    wr_ptr;
  logic [cmd_ptr_width-1:0]    rd_ptr;
  logic [cmd_ptr_width-1:0]    rd_ptr_1;
  logic [cmd_ptr_width:0]      count;
  logic [cmd_credit_width-1:0] pop_cnt;

  assign pop_cnt  = cmd_credit_width'(pop0) + cmd_credit_width'(pop1);
  assign rd_ptr_1 = rd_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (cmd_push) begin
      opcode_mem[wr_ptr] <= cmd_opcode;
      vd_mem[wr_ptr]     <= cmd_vd;
      vs1_mem[wr_ptr]    <= cmd_vs1;
      vs2_mem[wr_ptr]    <= cmd_vs2;
      lmul_mem[wr_ptr]   <= cmd_lmul;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      cmd_credit_ret <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + cmd_ptr_width'(pop_cnt);
      count  <= count + (cmd_ptr_width+1)'(cmd_push) - (cmd_ptr_width+1)'(pop_cnt);
      // one credit back per command that left last cycle
      cmd_credit_ret <= pop_cnt;
    end
  end

  // two oldest entries, head first
  assign pkg0_valid  = (count != '0);
  assign pkg0_opcode = opcode_mem[rd_ptr];
  assign pkg0_vd     = vd_mem[rd_ptr];
  assign pkg0_vs1    = vs1_mem[rd_ptr];
  assign pkg0_vs2    = vs2_mem[rd_ptr];
  assign pkg0_lmul   = lmul_mem[rd_ptr];
  assign pkg1_valid  = (count > (cmd_ptr_width+1)'(1));
  assign pkg1_opcode = opcode_mem[rd_ptr_1];
  assign pkg1_vd     = vd_mem[rd_ptr_1];
  assign pkg1_vs1    = vs1_mem[rd_ptr_1];
  assign pkg1_vs2    = vs2_mem[rd_ptr_1];
  assign pkg1_lmul   = lmul_mem[rd_ptr_1];

  // sender must hold a credit, so a full queue never sees a push
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_push |-> count < (cmd_ptr_width+1)'(cmd_depth));

  a_pop_order: assert property (@(posedge clk) disable iff (!arst_n)
    pop1 |-> pop0);

  a_pop_present: assert property (@(posedge clk) disable iff (!arst_n)
    !((pop0 && !pkg0_valid) || (pop1 && !pkg1_valid)));

endmodule

// ==== design/rvv_uop_pkg.sv ====
// rvv decode encodings: vector opcodes and register group sizes
package rvv_uop_pkg;

  localparam int opcode_width = 2;
  localparam int lmul_width   = 2;

  // operations pass through decode unchanged
  typedef enum logic [opcode_width-1:0] {
    OP_VADD = 2'd0,
    OP_VSUB = 2'd1,
    OP_VMUL = 2'd2,
    OP_VAND = 2'd3
  } opcode_e;

  // register group size, one uop per member
  typedef enum logic [lmul_width-1:0] {
    LMUL_1 = 2'd0,
    LMUL_2 = 2'd1,
    LMUL_4 = 2'd2,
    LMUL_8 = 2'd3
  } lmul_e;

endpackage

// ==== design/rvv_cfg_pkg.sv ====
// rvv decode sizing: queue depths, decode window and register field widths
package rvv_cfg_pkg;

  // command queue
  localparam int cmd_depth        = 8;
  localparam int cmd_ptr_width    = $clog2(cmd_depth);
  localparam int cmd_credit_width = 2;

  // uop queue
  localparam int uq_depth         = 16;
  localparam int uq_ptr_width     = $clog2(uq_depth);

  // decode window, counts run 0 to num_de_uop
  localparam int num_de_uop       = 4;
  localparam int num_de_uop_width = 3;
  localparam int de_sel_width     = $clog2(num_de_uop);

  // register fields
  localparam int uop_index_width  = 3;
  localparam int vreg_width       = 5;

endpackage
